// File: board_ctrl_pkg.sv
/*
  Board control shared definitions
  Bus widths, register map and button FSM state encoding
*/
package board_ctrl_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  parameter int data_w        = 32;
  parameter int addr_w        = 4;

  // Per-channel front-end word, low bit first:
  // tx_enable_a, tx_enable_b, txrx_v1, txrx_v2, rx_v1, rx_v2,
  // led_rx, led_txrx_rx, led_txrx_tx
  parameter int fe_ctrl_w     = 9;

  // Reference status, low bit first: reflck, is_pps, is_10meg, plllck
  parameter int tcxo_status_w = 4;

  typedef logic [data_w-1:0]    data_t;
  typedef logic [fe_ctrl_w-1:0] fe_ctrl_t;

  // ------------------------------
  // Register map
  // ------------------------------
  typedef enum logic [addr_w-1:0] {
    addr_ctrl0     = 4'd0,
    addr_ctrl1     = 4'd1,
    // Bit 0 press, bit 1 release
    addr_irq_mask  = 4'd2,
    // Read only, pps level above the tcxo bits
    addr_status    = 4'd3,
    // Read only, free running PPS edge count
    addr_pps_count = 4'd4
  } reg_addr_e;

  // ------------------------------
  // Button FSM states
  // ------------------------------
  typedef enum logic [1:0] {
    st_released,
    st_press_seen,
    st_pressed,
    st_release_seen
  } button_state_e;

endpackage

// File: reg_bus_if.sv
/*
  Register bus with valid/ready command and response channels
*/
`timescale 1ns/1ps

interface reg_bus_if import board_ctrl_pkg::*;;

  // Command channel
  logic      cmd_valid;
  logic      cmd_ready;
  logic      cmd_write;
  reg_addr_e cmd_addr;
  data_t     cmd_wdata;

  // Response channel
  logic      rsp_valid;
  logic      rsp_ready;
  data_t     rsp_rdata;

  modport host (
    output cmd_valid, cmd_write, cmd_addr, cmd_wdata, rsp_ready,
    input  cmd_ready, rsp_valid, rsp_rdata
  );

  modport regs (
    input  cmd_valid, cmd_write, cmd_addr, cmd_wdata, rsp_ready,
    output cmd_ready, rsp_valid, rsp_rdata
  );

endinterface

// File: button_fsm.sv
/*
  Power button edge detector
  Confirms each switch level on two samples, emits press and release pulses
*/
`timescale 1ns/1ps

module button_fsm import board_ctrl_pkg::*; (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic onswitch_n,
  output logic press,
  output logic release_evt
);

  button_state_e state_q;
  button_state_e state_d;

  // Switch is active low
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_released: begin
        if (!onswitch_n) begin
          state_d = st_press_seen;
        end
      end
      st_press_seen: begin
        // Second low sample confirms the press, otherwise a glitch
        state_d = onswitch_n ? st_released : st_pressed;
      end
      st_pressed: begin
        if (onswitch_n) begin
          state_d = st_release_seen;
        end
      end
      st_release_seen: begin
        state_d = onswitch_n ? st_released : st_pressed;
      end
      default: state_d = st_released;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state_q     <= st_released;
      press       <= 1'b0;
      release_evt <= 1'b0;
    end else begin
      state_q     <= state_d;
      // One cycle pulse on each confirmed transition
      press       <= (state_q == st_press_seen) && (state_d == st_pressed);
      release_evt <= (state_q == st_release_seen) && (state_d == st_released);
    end
  end

endmodule

// File: irq_stretch_timer.sv
/*
  Interrupt pulse stretcher
  Holds irq high for STRETCH_CYCLES cycles after the latest trigger
*/
`timescale 1ns/1ps

module irq_stretch_timer #(
  parameter int STRETCH_CYCLES = 8
) (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic trigger,
  output logic irq
);

  localparam int cnt_w = $clog2(STRETCH_CYCLES + 1);

  logic [cnt_w-1:0] count;

  // ------------------------------
  // Down counter
  // ------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      count <= '0;
    end else if (trigger) begin
      // A new event restarts the full hold time
      count <= cnt_w'(STRETCH_CYCLES);
    end else if (count != '0) begin
      count <= count - cnt_w'(1);
    end
  end

  assign irq = (count != '0);

endmodule

// File: signal_sync.sv
/*
  Synchronizers for GPS PPS and the reference clock status bits
  Also counts PPS rising edges after synchronization
*/
`timescale 1ns/1ps

module signal_sync import board_ctrl_pkg::*; (
  input  logic                     bus_clk,
  input  logic                     bus_rst,
  input  logic                     gps_pps,
  input  logic [tcxo_status_w-1:0] tcxo_status,
  output logic                     pps_level,
  output data_t                    pps_count,
  output logic [tcxo_status_w-1:0] status_sync
);

  logic [2:0]               pps_reg;
  logic                     pps_prev;
  logic [tcxo_status_w-1:0] st_rsync;

  // ------------------------------
  // PPS path
  // ------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      pps_reg   <= '0;
      pps_prev  <= 1'b0;
      pps_count <= '0;
    end else begin
      pps_reg  <= {pps_reg[1:0], gps_pps};
      pps_prev <= pps_reg[2];
      // Wraps at full width
      if (pps_reg[2] && !pps_prev) begin
        pps_count <= pps_count + data_w'(1);
      end
    end
  end

  assign pps_level = pps_reg[2];

  // Status bits come from the reference clock domain
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      st_rsync    <= '0;
      status_sync <= '0;
    end else begin
      st_rsync    <= tcxo_status;
      status_sync <= st_rsync;
    end
  end

endmodule

// File: ctrl_regs.sv
/*
  Board control register bank
  One command in flight, front-end control words, interrupt mask and readback
*/
`timescale 1ns/1ps

module ctrl_regs import board_ctrl_pkg::*; (
  input  logic                     bus_clk,
  input  logic                     bus_rst,
  reg_bus_if.regs                  bus,
  input  logic                     press_irq_raw,
  input  logic                     release_irq_raw,
  input  logic                     pps_level,
  input  data_t                    pps_count,
  input  logic [tcxo_status_w-1:0] status_sync,
  output logic                     irq_press,
  output logic                     irq_release,
  output fe_ctrl_t                 fe_ctrl0,
  output fe_ctrl_t                 fe_ctrl1
);

  logic       rsp_pending;
  logic       cmd_fire;
  logic       rsp_fire;
  logic [1:0] irq_mask;
  data_t      rd_data;

  // ------------------------------
  // Handshake
  // ------------------------------
  assign bus.cmd_ready = !rsp_pending;
  assign bus.rsp_valid = rsp_pending;

  assign cmd_fire = bus.cmd_valid && bus.cmd_ready;
  assign rsp_fire = bus.rsp_valid && bus.rsp_ready;

  // Response stays up until the host takes it
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rsp_pending <= 1'b0;
    end else if (cmd_fire) begin
      rsp_pending <= 1'b1;
    end else if (rsp_fire) begin
      rsp_pending <= 1'b0;
    end
  end

  // ------------------------------
  // Read decode
  // ------------------------------
  always_comb begin
    case (bus.cmd_addr)
      addr_ctrl0:     rd_data = data_w'(fe_ctrl0);
      addr_ctrl1:     rd_data = data_w'(fe_ctrl1);
      addr_irq_mask:  rd_data = data_w'(irq_mask);
      addr_status:    rd_data = data_w'({pps_level, status_sync});
      addr_pps_count: rd_data = pps_count;
      default:        rd_data = '0;
    endcase
  end

  // Captured at acceptance, writes answer with zero
  always_ff @(posedge bus_clk) begin
    if (cmd_fire) begin
      bus.rsp_rdata <= bus.cmd_write ? '0 : rd_data;
    end
  end

  // ------------------------------
  // Writable registers
  // ------------------------------
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      fe_ctrl0 <= '0;
      fe_ctrl1 <= '0;
      irq_mask <= '0;
    end else if (cmd_fire && bus.cmd_write) begin
      case (bus.cmd_addr)
        addr_ctrl0:    fe_ctrl0 <= bus.cmd_wdata[fe_ctrl_w-1:0];
        addr_ctrl1:    fe_ctrl1 <= bus.cmd_wdata[fe_ctrl_w-1:0];
        addr_irq_mask: irq_mask <= bus.cmd_wdata[1:0];
        // Read-only and unmapped addresses ignore writes
        default: ;
      endcase
    end
  end

  // Stretched button lines gated per source
  assign irq_press   = press_irq_raw && irq_mask[0];
  assign irq_release = release_irq_raw && irq_mask[1];

endmodule

// File: board_ctrl.sv
/*
  Board control top level
  Button interrupts, PPS and reference status sync, front-end control registers
*/
`timescale 1ns/1ps

module board_ctrl import board_ctrl_pkg::*; #(
  parameter int STRETCH_CYCLES = 8
) (
  input  logic                     bus_clk,
  input  logic                     bus_rst,
  // Command channel
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  logic                     cmd_write,
  input  reg_addr_e                cmd_addr,
  input  data_t                    cmd_wdata,
  // Response channel
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output data_t                    rsp_rdata,
  // Board inputs
  input  logic                     onswitch_n,
  input  logic                     gps_pps,
  input  logic [tcxo_status_w-1:0] tcxo_status,
  // Board outputs
  output logic                     irq_press,
  output logic                     irq_release,
  output fe_ctrl_t                 fe_ctrl0,
  output fe_ctrl_t                 fe_ctrl1
);

  logic                     press_evt;
  logic                     release_evt;
  logic                     press_irq_raw;
  logic                     release_irq_raw;
  logic                     pps_level;
  data_t                    pps_count;
  logic [tcxo_status_w-1:0] status_sync;

  reg_bus_if bus ();

  // ------------------------------
  // Host side of the register bus
  // ------------------------------
  assign bus.cmd_valid = cmd_valid;
  assign bus.cmd_write = cmd_write;
  assign bus.cmd_addr  = cmd_addr;
  assign bus.cmd_wdata = cmd_wdata;
  assign bus.rsp_ready = rsp_ready;
  assign cmd_ready     = bus.cmd_ready;
  assign rsp_valid     = bus.rsp_valid;
  assign rsp_rdata     = bus.rsp_rdata;

  button_fsm u_button (
    .bus_clk, .bus_rst, .onswitch_n,
    .press       (press_evt),
    .release_evt (release_evt)
  );

  irq_stretch_timer #(.STRETCH_CYCLES(STRETCH_CYCLES)) u_press_stretch (
    .bus_clk, .bus_rst,
    .trigger (press_evt),
    .irq     (press_irq_raw)
  );

  irq_stretch_timer #(.STRETCH_CYCLES(STRETCH_CYCLES)) u_release_stretch (
    .bus_clk, .bus_rst,
    .trigger (release_evt),
    .irq     (release_irq_raw)
  );

  signal_sync u_sync (
    .bus_clk, .bus_rst, .gps_pps, .tcxo_status,
    .pps_level, .pps_count, .status_sync
  );

  ctrl_regs u_regs (
    .bus_clk, .bus_rst,
    .bus             (bus.regs),
    .press_irq_raw, .release_irq_raw,
    .pps_level, .pps_count, .status_sync,
    .irq_press, .irq_release,
    .fe_ctrl0, .fe_ctrl1
  );

endmodule

// File: board_ctrl_asserts.sv
/*
  Register bank protocol and interrupt mask checks
*/
`timescale 1ns/1ps

module board_ctrl_asserts import board_ctrl_pkg::*; (
  input logic       bus_clk,
  input logic       bus_rst,
  input logic       cmd_valid,
  input logic       cmd_ready,
  input logic       rsp_valid,
  input logic       rsp_ready,
  input data_t      rsp_rdata,
  input logic [1:0] irq_mask,
  input logic       irq_press,
  input logic       irq_release
);

  int fail_count = 0;

  // ------------------------------
  // Response channel
  // ------------------------------
  rsp_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
    else begin
      fail_count++;
      $error("response dropped or changed before it was taken");
    end

  // One command in flight, the accepted one owns the port
  one_in_flight: assert property (@(posedge bus_clk) disable iff (bus_rst)
    cmd_valid && cmd_ready |=> rsp_valid && !cmd_ready)
    else begin
      fail_count++;
      $error("accepted command did not raise a response or block the command port");
    end

  // ------------------------------
  // Interrupt gating
  // ------------------------------
  press_masked: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !irq_mask[0] |-> !irq_press)
    else begin
      fail_count++;
      $error("irq_press high with its mask bit clear");
    end

  release_masked: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !irq_mask[1] |-> !irq_release)
    else begin
      fail_count++;
      $error("irq_release high with its mask bit clear");
    end

endmodule

// File: board_ctrl_tb.sv
/*
  Board control testbench
  Register traffic with stalls, sync paths and button interrupts
*/
`timescale 1ns/1ps

module board_ctrl_tb import board_ctrl_pkg::*; ();

  localparam int stretch_cycles = 8;
  // Whole sequence runs well under a thousand cycles
  localparam int timeout_cycles = 5000;

  logic                     bus_clk;
  logic                     bus_rst;
  logic                     cmd_valid;
  logic                     cmd_ready;
  logic                     cmd_write;
  reg_addr_e                cmd_addr;
  data_t                    cmd_wdata;
  logic                     rsp_valid;
  logic                     rsp_ready;
  data_t                    rsp_rdata;
  logic                     onswitch_n;
  logic                     gps_pps;
  logic [tcxo_status_w-1:0] tcxo_status;
  logic                     irq_press;
  logic                     irq_release;
  fe_ctrl_t                 fe_ctrl0;
  fe_ctrl_t                 fe_ctrl1;

  // Model state of the register map
  fe_ctrl_t                 shadow_ctrl0 = '0;
  fe_ctrl_t                 shadow_ctrl1 = '0;
  logic [1:0]               shadow_mask = '0;
  logic [tcxo_status_w-1:0] exp_status = '0;
  logic                     exp_pps_level = 1'b0;
  data_t                    exp_pps_count = '0;

  data_t     exp_q[$];
  reg_addr_e addr_q[$];
  int        error_count = 0;
  int        check_count = 0;
  int        cycle_count = 0;
  bit        stall_en = 1'b0;

  board_ctrl #(.STRETCH_CYCLES(stretch_cycles)) uut (.*);

  bind ctrl_regs board_ctrl_asserts u_asserts (
    .bus_clk, .bus_rst,
    .cmd_valid (bus.cmd_valid),
    .cmd_ready (bus.cmd_ready),
    .rsp_valid (bus.rsp_valid),
    .rsp_ready (bus.rsp_ready),
    .rsp_rdata (bus.rsp_rdata),
    .irq_mask, .irq_press, .irq_release
  );

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  always @(posedge bus_clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: run did not finish within %0d clock cycles", timeout_cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_data(input data_t got, input data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_fe(input fe_ctrl_t got, input fe_ctrl_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Expected read data from the model state
  function automatic data_t expected_read(input reg_addr_e addr);
    case (addr)
      addr_ctrl0:     return data_w'(shadow_ctrl0);
      addr_ctrl1:     return data_w'(shadow_ctrl1);
      addr_irq_mask:  return data_w'(shadow_mask);
      addr_status:    return data_w'({exp_pps_level, exp_status});
      addr_pps_count: return exp_pps_count;
      default:        return '0;
    endcase
  endfunction

  // Every accepted response against the queued expectation
  always @(posedge bus_clk) begin
    if (!bus_rst && rsp_valid && rsp_ready) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Unexpected response at %0t ns with no command outstanding", $time);
      end else begin
        check_data(rsp_rdata, exp_q.pop_front(),
                   $sformatf("response for address %0d", addr_q.pop_front()));
      end
    end
  end

  // One command, then wait until its response is taken
  task automatic bus_cmd(input logic wr, input reg_addr_e addr, input data_t wdata);
    bit done;
    cmd_valid <= 1'b1;
    cmd_write <= wr;
    cmd_addr  <= addr;
    cmd_wdata <= wdata;
    done = 1'b0;
    while (!done) begin
      @(posedge bus_clk);
      done = cmd_ready;
    end
    exp_q.push_back(wr ? '0 : expected_read(addr));
    addr_q.push_back(addr);
    if (wr) begin
      case (addr)
        addr_ctrl0:    shadow_ctrl0 = wdata[fe_ctrl_w-1:0];
        addr_ctrl1:    shadow_ctrl1 = wdata[fe_ctrl_w-1:0];
        addr_irq_mask: shadow_mask  = wdata[1:0];
        default: ;
      endcase
    end
    cmd_valid <= 1'b0;
    done = 1'b0;
    while (!done) begin
      rsp_ready <= !stall_en || ($urandom_range(3) != 0);
      @(posedge bus_clk);
      done = rsp_valid && rsp_ready;
    end
  endtask

  task automatic wait_irq(input bit use_release, input logic level, input int max_cycles,
                          input string what);
    int   n;
    logic val;
    n   = 0;
    val = use_release ? irq_release : irq_press;
    while (val !== level && n < max_cycles) begin
      @(posedge bus_clk);
      n++;
      val = use_release ? irq_release : irq_press;
    end
    check_bit(val, level, what);
  endtask

  task automatic watch_quiet(input int cycles);
    repeat (cycles) begin
      @(posedge bus_clk);
      check_bit(irq_press, 1'b0, "irq_press");
      check_bit(irq_release, 1'b0, "irq_release");
    end
  endtask

  initial begin
    reg_addr_e addr;
    int        fails;
    void'($urandom(89032));
    bus_rst     = 1'b1;
    cmd_valid   = 1'b0;
    cmd_write   = 1'b0;
    cmd_addr    = addr_ctrl0;
    cmd_wdata   = '0;
    rsp_ready   = 1'b1;
    onswitch_n  = 1'b1;
    gps_pps     = 1'b0;
    tcxo_status = '0;
    repeat (3) @(posedge bus_clk);
    bus_rst <= 1'b0;
    @(posedge bus_clk);

    // Front-end words with response stalls
    stall_en = 1'b1;
    repeat (20) begin
      addr = ($urandom_range(1) == 0) ? addr_ctrl0 : addr_ctrl1;
      bus_cmd(1'b1, addr, data_t'($urandom()));
      check_fe(fe_ctrl0, shadow_ctrl0, "fe_ctrl0");
      check_fe(fe_ctrl1, shadow_ctrl1, "fe_ctrl1");
      bus_cmd(1'b0, addr_ctrl0, '0);
      bus_cmd(1'b0, addr_ctrl1, '0);
    end
    stall_en = 1'b0;

    // Read-only and unmapped addresses
    bus_cmd(1'b1, addr_status, data_t'($urandom()));
    bus_cmd(1'b1, addr_pps_count, data_t'($urandom()));
    for (int a = 5; a < 16; a += 5) begin
      bus_cmd(1'b1, reg_addr_e'(a), data_t'($urandom()));
      bus_cmd(1'b0, reg_addr_e'(a), '0);
    end
    for (int a = 0; a < 5; a++) begin
      bus_cmd(1'b0, reg_addr_e'(a), '0);
    end
    check_fe(fe_ctrl0, shadow_ctrl0, "fe_ctrl0");
    check_fe(fe_ctrl1, shadow_ctrl1, "fe_ctrl1");

    // Reference status through the two-flop sync
    repeat (4) begin
      exp_status = tcxo_status_w'($urandom_range(15));
      tcxo_status <= exp_status;
      repeat (6) @(posedge bus_clk);
      bus_cmd(1'b0, addr_status, '0);
    end

    // PPS pulses
    repeat (5) begin
      gps_pps <= 1'b1;
      repeat ($urandom_range(4, 8)) @(posedge bus_clk);
      gps_pps <= 1'b0;
      repeat ($urandom_range(4, 8)) @(posedge bus_clk);
    end
    exp_pps_count = data_t'(5);
    bus_cmd(1'b0, addr_pps_count, '0);
    gps_pps <= 1'b1;
    exp_pps_level = 1'b1;
    exp_pps_count = exp_pps_count + data_t'(1);
    repeat (6) @(posedge bus_clk);
    bus_cmd(1'b0, addr_status, '0);
    bus_cmd(1'b0, addr_pps_count, '0);

    // Button events, both sources unmasked
    bus_cmd(1'b1, addr_irq_mask, data_t'(3));
    onswitch_n <= 1'b0;
    wait_irq(1'b0, 1'b1, 8, "irq_press rise");
    check_bit(irq_release, 1'b0, "irq_release during press");
    wait_irq(1'b0, 1'b0, stretch_cycles + 4, "irq_press fall");
    onswitch_n <= 1'b1;
    wait_irq(1'b1, 1'b1, 8, "irq_release rise");
    check_bit(irq_press, 1'b0, "irq_press during release");
    wait_irq(1'b1, 1'b0, stretch_cycles + 4, "irq_release fall");

    // Single-sample glitch
    onswitch_n <= 1'b0;
    @(posedge bus_clk);
    onswitch_n <= 1'b1;
    watch_quiet(20);

    // Full press and release with the mask cleared
    bus_cmd(1'b1, addr_irq_mask, '0);
    bus_cmd(1'b0, addr_irq_mask, '0);
    onswitch_n <= 1'b0;
    watch_quiet(20);
    onswitch_n <= 1'b1;
    watch_quiet(20);

    if (exp_q.size() != 0) begin
      error_count++;
      $display("%0d responses never arrived", exp_q.size());
    end
    fails = uut.u_regs.u_asserts.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, fails);
    if (error_count == 0 && fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: board_ctrl.f
board_ctrl_pkg.sv
reg_bus_if.sv
button_fsm.sv
irq_stretch_timer.sv
signal_sync.sv
ctrl_regs.sv
board_ctrl.sv
board_ctrl_asserts.sv
board_ctrl_tb.sv

// File: Bender.yml
package:
  name: board_ctrl

sources:
  - files:
      - board_ctrl_pkg.sv
      - reg_bus_if.sv
      - button_fsm.sv
      - irq_stretch_timer.sv
      - signal_sync.sv
      - ctrl_regs.sv
      - board_ctrl.sv
  - target: test
    files:
      - board_ctrl_asserts.sv
      - board_ctrl_tb.sv
